/* logic/bp_pkg.sv */
// Shared sizes, PC field positions and counter encoding for the branch predictor
// Imported by every block of the fetch front end
package bp_pkg;

	// Table geometry
	localparam int btb_row     = 16;                   // Rows in BTB and BHT
	localparam int index_width = $clog2(btb_row);      // Index bits taken from the PC

	// Field positions inside a fetch address
	localparam int index_lsb   = 2;                    // Word aligned so bits 1:0 skipped
	localparam int tag_lsb     = index_lsb + index_width; // Tag sits right above the index
	localparam int tag_size    = 10;                   // PC bits 15:6
	localparam int target_lsb  = 2;                    // Stored target starts at bit 2
	localparam int target_size = 12;                   // PC bits 13:2

	// 32-bit word address
	typedef logic [31:0] pc_t;

	localparam pc_t reset_pc = 32'h0000_1000;          // First fetch after reset
	localparam pc_t pc_step  = 32'd4;                  // Sequential fetch increment

	// Two bit saturating counter
	// MSB of each state is the taken prediction
	typedef enum logic [1:0] {
		strong_not_taken = 2'b00,
		weak_not_taken   = 2'b01,                      // Reset state
		weak_taken       = 2'b10,
		strong_taken     = 2'b11
	} bht_state_t;

endpackage

/* logic/fetch_pc_reg.sv */
// Fetch PC register for the front end
// Loads a redirect target or the predicted next PC each enabled cycle
module fetch_pc_reg (
	input  logic        clock,
	input  logic        reset,
	input  logic        enable,      // Low stalls the fetch stage
	input  logic        redirect,    // Strobe from execute on a wrong path
	input  bp_pkg::pc_t redirect_pc, // Corrected fetch address
	input  bp_pkg::pc_t next_pc,     // Prediction from next_pc_select
	output bp_pkg::pc_t fetch_pc     // Address being fetched this cycle
);
	import bp_pkg::*;

	// Source for the next fetch address
	// Redirect always wins over the prediction
	pc_t load_pc;

	always_comb begin
		if (redirect) begin
			load_pc = redirect_pc;  // Execute knows better
		end else begin
			load_pc = next_pc;      // Predicted or sequential
		end
	end

	// PC holds while the stage is stalled
	always_ff @(posedge clock) begin
		if (reset) begin
			fetch_pc <= reset_pc;   // Boot address
		end else if (enable) begin
			fetch_pc <= load_pc;
		end
	end

endmodule

/* logic/btb.sv */
// Direct mapped branch target buffer with 16 rows
// Taken resolutions write a row and are forwarded into the same cycle lookup
module btb (
	input  logic        clock,
	input  logic        reset,
	input  logic        enable,          // Stage enable, gates both update and hit
	input  bp_pkg::pc_t fetch_pc,        // Current fetch address
	input  logic        if_branch,       // Fetch word is a branch
	input  bp_pkg::pc_t ex_pc,           // PC of the resolved branch
	input  bp_pkg::pc_t calculated_pc,   // Target computed in execute
	input  logic        ex_branch_taken, // Resolved direction
	input  logic        ex_en_branch,    // A branch resolved this cycle
	output bp_pkg::pc_t target_pc,       // Predicted target, fetch_pc on a miss
	output logic        valid_target     // Hit in the table
);
	import bp_pkg::*;

	// Table storage
	logic [btb_row-1:0]     valid_q;                  // One valid bit per row
	logic [tag_size-1:0]    tag_q    [btb_row];       // PC bits 15:6
	logic [target_size-1:0] target_q [btb_row];       // Target bits 13:2

	// Update side fields
	logic                   update;
	logic [index_width-1:0] ex_index;
	logic [tag_size-1:0]    ex_tag;
	logic [target_size-1:0] ex_target;

	// Lookup side fields
	logic [index_width-1:0] fetch_index;
	logic [tag_size-1:0]    fetch_tag;

	// Row seen by the lookup after this cycle's write
	logic                   row_valid;
	logic [tag_size-1:0]    row_tag;
	logic [target_size-1:0] row_target;

	// Only taken branches allocate or refresh a row
	// Not taken ones leave the entry alone
	assign update    = enable & ex_en_branch & ex_branch_taken;
	assign ex_index  = ex_pc[tag_lsb-1:index_lsb];
	assign ex_tag    = ex_pc[tag_lsb+tag_size-1:tag_lsb];
	assign ex_target = calculated_pc[target_lsb+target_size-1:target_lsb];

	assign fetch_index = fetch_pc[tag_lsb-1:index_lsb];
	assign fetch_tag   = fetch_pc[tag_lsb+tag_size-1:tag_lsb];

	// Bypass a write to the same row into the lookup
	always_comb begin
		row_valid  = valid_q[fetch_index];
		row_tag    = tag_q[fetch_index];
		row_target = target_q[fetch_index];
		if (update && (ex_index == fetch_index)) begin
			row_valid  = 1'b1;       // Row becomes valid at this edge
			row_tag    = ex_tag;
			row_target = ex_target;
		end
	end

	// Hit needs a branch in fetch and a matching tag
	assign valid_target = enable & if_branch & row_valid & (row_tag == fetch_tag);

	// Splice stored bits 13:2 into the fetch PC
	// Upper bits and byte offset come from fetch_pc
	always_comb begin
		target_pc = fetch_pc;
		if (valid_target) begin
			target_pc[target_lsb+target_size-1:target_lsb] = row_target;
		end
	end

	// A row turns valid on its first taken write
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else if (update) begin
			valid_q[ex_index] <= 1'b1;
		end
	end

	// Tag and target payload
	always_ff @(posedge clock) begin
		if (update) begin
			tag_q[ex_index]    <= ex_tag;
			target_q[ex_index] <= ex_target;
		end
	end

endmodule

/* logic/bht.sv */
// Branch history table of 2-bit saturating direction counters
// Every resolved branch trains the counter at its index
module bht (
	input  logic        clock,
	input  logic        reset,
	input  logic        enable,          // Stalled stage ignores training
	input  bp_pkg::pc_t fetch_pc,        // Current fetch address
	input  bp_pkg::pc_t ex_pc,           // PC of the resolved branch
	input  logic        ex_branch_taken, // Resolved direction
	input  logic        ex_en_branch,    // A branch resolved this cycle
	output logic        predict_taken    // Direction guess for fetch_pc
);
	import bp_pkg::*;

	bht_state_t             ctr_q [btb_row];  // One counter per row

	logic                   train;
	logic [index_width-1:0] ex_index;
	logic [index_width-1:0] fetch_index;
	bht_state_t             ex_next;          // Trained value for the ex row
	bht_state_t             fetch_state;      // Post update counter at fetch row

	// One step toward the resolved direction
	// Saturates at both strong states
	function automatic bht_state_t step(input bht_state_t cur, input logic taken);
		bht_state_t nxt;
		case (cur)
			strong_not_taken: nxt = taken ? weak_not_taken : strong_not_taken;
			weak_not_taken:   nxt = taken ? weak_taken     : strong_not_taken;
			weak_taken:       nxt = taken ? strong_taken   : weak_not_taken;
			default:          nxt = taken ? strong_taken   : weak_taken;
		endcase
		return nxt;
	endfunction

	// Taken and not taken resolutions both train
	assign train       = enable & ex_en_branch;
	assign ex_index    = ex_pc[tag_lsb-1:index_lsb];
	assign fetch_index = fetch_pc[tag_lsb-1:index_lsb];
	assign ex_next     = step(ctr_q[ex_index], ex_branch_taken);

	// Same row written this cycle is forwarded
	always_comb begin
		if (train && (ex_index == fetch_index)) begin
			fetch_state = ex_next;
		end else begin
			fetch_state = ctr_q[fetch_index];
		end
	end

	assign predict_taken = fetch_state[1];  // MSB carries the direction

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < btb_row; i++) begin
				ctr_q[i] <= weak_not_taken;  // Slight bias to fall through
			end
		end else if (train) begin
			ctr_q[ex_index] <= ex_next;
		end
	end

endmodule

/* logic/next_pc_select.sv */
// Next fetch address selection
// Follows the BTB target only when the BHT also predicts taken
module next_pc_select (
	input  bp_pkg::pc_t fetch_pc,      // Current fetch address
	input  bp_pkg::pc_t target_pc,     // Spliced target from the BTB
	input  logic        valid_target,  // BTB hit
	input  logic        predict_taken, // BHT direction
	output bp_pkg::pc_t next_pc,       // Address for the next fetch
	output logic        pred_taken     // Front end follows the target
);
	import bp_pkg::*;

	pc_t seq_pc;  // Fall through address

	// Sequential word after the current fetch
	assign seq_pc = fetch_pc + pc_step;

	// Both a known target and a taken guess are needed
	// A hit with a not taken counter still falls through
	assign pred_taken = valid_target & predict_taken;

	always_comb begin
		if (pred_taken) begin
			next_pc = target_pc;   // Jump to predicted target
		end else begin
			next_pc = seq_pc;
		end
	end

endmodule

/* logic/bp_frontend.sv */
// Branch prediction front end for the fetch stage
// Ties the PC register, BTB, BHT and next PC selection together
module bp_frontend (
	input  logic        clock,
	input  logic        reset,
	input  logic        enable,          // Fetch stage enable, low stalls
	input  logic        if_branch,       // Fetch word is a branch
	input  logic        ex_en_branch,    // Branch resolved in execute
	input  bp_pkg::pc_t ex_pc,           // PC of the resolved branch
	input  bp_pkg::pc_t calculated_pc,   // Resolved target
	input  logic        ex_branch_taken, // Resolved direction
	input  logic        redirect,        // Load redirect_pc next edge
	input  bp_pkg::pc_t redirect_pc,
	output bp_pkg::pc_t fetch_pc,        // Address fetched this cycle
	output bp_pkg::pc_t next_pc,         // Address for the next cycle
	output logic        pred_taken,      // Predicted taken branch
	output logic        valid_target     // BTB hit
);
	import bp_pkg::*;

	pc_t  target_pc;      // BTB target to the selector
	logic predict_taken;  // BHT direction to the selector

	// PC register closes the loop through next_pc
	fetch_pc_reg u_fetch_pc_reg (
		.clock       (clock),
		.reset       (reset),
		.enable      (enable),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.next_pc     (next_pc),
		.fetch_pc    (fetch_pc)
	);

	btb u_btb (
		.clock           (clock),
		.reset           (reset),
		.enable          (enable),
		.fetch_pc        (fetch_pc),
		.if_branch       (if_branch),
		.ex_pc           (ex_pc),
		.calculated_pc   (calculated_pc),
		.ex_branch_taken (ex_branch_taken),
		.ex_en_branch    (ex_en_branch),
		.target_pc       (target_pc),
		.valid_target    (valid_target)  // Also seen outside
	);

	bht u_bht (
		.clock           (clock),
		.reset           (reset),
		.enable          (enable),
		.fetch_pc        (fetch_pc),
		.ex_pc           (ex_pc),
		.ex_branch_taken (ex_branch_taken),
		.ex_en_branch    (ex_en_branch),
		.predict_taken   (predict_taken)
	);

	next_pc_select u_next_pc_select (
		.fetch_pc      (fetch_pc),
		.target_pc     (target_pc),
		.valid_target  (valid_target),
		.predict_taken (predict_taken),
		.next_pc       (next_pc),
		.pred_taken    (pred_taken)
	);

endmodule

/* verif/bp_frontend_tb.sv */
// Self-checking testbench for the branch prediction front end
// Applies one line of verif/bp_patterns.txt per cycle and checks the outputs before the next edge
module bp_frontend_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import bp_pkg::*;

	localparam int    clock_period = 40;
	localparam int    reset_cycles = 4;
	localparam int    check_offset = 5;                 // Sample this long before rising edge
	localparam string pattern_file = "verif/bp_patterns.txt";

	// DUT inputs
	logic clock = 1'b0;
	logic reset;
	logic enable;
	logic if_branch;
	logic ex_en_branch;
	pc_t  ex_pc;
	pc_t  calculated_pc;
	logic ex_branch_taken;
	logic redirect;
	pc_t  redirect_pc;

	// DUT outputs
	pc_t  fetch_pc;
	pc_t  next_pc;
	logic pred_taken;
	logic valid_target;

	// Pattern columns, one entry per cycle
	logic vec_enable       [$];
	logic vec_if_branch    [$];
	logic vec_ex_en_branch [$];
	pc_t  vec_ex_pc        [$];
	pc_t  vec_calc_pc      [$];
	logic vec_ex_taken     [$];
	logic vec_redirect     [$];
	pc_t  vec_redirect_pc  [$];
	pc_t  vec_fetch_pc     [$];    // Expected outputs from here on
	pc_t  vec_next_pc      [$];
	logic vec_pred_taken   [$];
	logic vec_valid_target [$];

	int num_vectors;
	int vec_idx;
	int error_count;
	int check_count;
	bit patterns_loaded = 1'b0;    // Starts the watchdog

	bp_frontend DUT (
		.clock           (clock),
		.reset           (reset),
		.enable          (enable),
		.if_branch       (if_branch),
		.ex_en_branch    (ex_en_branch),
		.ex_pc           (ex_pc),
		.calculated_pc   (calculated_pc),
		.ex_branch_taken (ex_branch_taken),
		.redirect        (redirect),
		.redirect_pc     (redirect_pc),
		.fetch_pc        (fetch_pc),
		.next_pc         (next_pc),
		.pred_taken      (pred_taken),
		.valid_target    (valid_target)
	);

	always #(clock_period / 2) clock = ~clock;    // 40 ns period

	task automatic compare_pc(input string name, input pc_t expected, input pc_t actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("[FAIL] %s expected %b actual %b", name, expected, actual);
		end
	endtask

	// Comment and blank lines scan zero fields and are skipped
	task automatic load_patterns();
		int               fd;
		int               fields;
		int               line_no;
		logic [8*256-1:0] line_buf;
		logic             t_en, t_ifb, t_exen, t_taken, t_redir, t_pt, t_vt;
		pc_t              t_ex_pc, t_calc, t_redir_pc, t_fetch, t_next;
		line_no = 0;
		fd = $fopen(pattern_file, "r");
		if (fd == 0) begin
			error_count++;
			$display("Cannot open pattern file %s", pattern_file);
		end else begin
			while (!$feof(fd)) begin
				line_buf = '0;
				if ($fgets(line_buf, fd) > 0) begin
					line_no++;
					fields = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h",
						t_en, t_ifb, t_exen, t_ex_pc, t_calc, t_taken, t_redir, t_redir_pc,
						t_fetch, t_next, t_pt, t_vt);
					if (fields == 12) begin
						vec_enable.push_back(t_en);
						vec_if_branch.push_back(t_ifb);
						vec_ex_en_branch.push_back(t_exen);
						vec_ex_pc.push_back(t_ex_pc);
						vec_calc_pc.push_back(t_calc);
						vec_ex_taken.push_back(t_taken);
						vec_redirect.push_back(t_redir);
						vec_redirect_pc.push_back(t_redir_pc);
						vec_fetch_pc.push_back(t_fetch);
						vec_next_pc.push_back(t_next);
						vec_pred_taken.push_back(t_pt);
						vec_valid_target.push_back(t_vt);
					end else if (fields > 0) begin
						error_count++;    // Truncated line
						$display("Pattern file line %0d has only %0d of 12 fields", line_no, fields);
					end
				end
			end
			$fclose(fd);
			if (vec_enable.size() == 0) begin
				error_count++;
				$display("Pattern file %s holds no stimulus lines", pattern_file);
			end
		end
		num_vectors     = vec_enable.size();
		patterns_loaded = 1'b1;
	endtask

	task automatic drive_vector(input int i);
		enable          = vec_enable[i];
		if_branch       = vec_if_branch[i];
		ex_en_branch    = vec_ex_en_branch[i];
		ex_pc           = vec_ex_pc[i];
		calculated_pc   = vec_calc_pc[i];
		ex_branch_taken = vec_ex_taken[i];
		redirect        = vec_redirect[i];
		redirect_pc     = vec_redirect_pc[i];
	endtask

	task automatic check_vector(input int i);
		compare_pc($sformatf("vector %0d fetch_pc", i), vec_fetch_pc[i], fetch_pc);
		compare_pc($sformatf("vector %0d next_pc", i), vec_next_pc[i], next_pc);
		compare_bit($sformatf("vector %0d pred_taken", i), vec_pred_taken[i], pred_taken);
		compare_bit($sformatf("vector %0d valid_target", i), vec_valid_target[i], valid_target);
	endtask

	initial begin
		reset           = 1'b1;
		enable          = 1'b0;
		if_branch       = 1'b0;
		ex_en_branch    = 1'b0;
		ex_pc           = '0;
		calculated_pc   = '0;
		ex_branch_taken = 1'b0;
		redirect        = 1'b0;
		redirect_pc     = '0;
		error_count     = 0;
		check_count     = 0;
		load_patterns();
		repeat (reset_cycles) @(posedge clock);
		// Reset drops on the same falling edge as the first vector
		for (vec_idx = 0; vec_idx < num_vectors; vec_idx++) begin
			@(negedge clock);
			reset = 1'b0;
			drive_vector(vec_idx);
			#(clock_period / 2 - check_offset);    // Outputs settled, edge not yet seen
			check_vector(vec_idx);
		end
		$display("Vectors: %0d  Checks: %0d  Errors: %0d", num_vectors, check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// Reset plus one cycle per vector, with ten cycles of margin
	initial begin : watchdog
		wait (patterns_loaded);
		#((num_vectors + 10) * clock_period);
		$display("Timeout after %0d cycles, the run did not finish", num_vectors + 10);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* vlog.f */
logic/bp_pkg.sv
logic/fetch_pc_reg.sv
logic/btb.sv
logic/bht.sv
logic/next_pc_select.sv
logic/bp_frontend.sv
verif/bp_frontend_tb.sv

/* verif/bp_patterns.txt */
# en if_br ex_en ex_pc calc_pc ex_tkn redir redir_pc exp_fetch exp_next exp_pred exp_valid
# One line per clock after reset, every field in hex
# Sequential fetch from reset_pc
1 0 0 00000000 00000000 0 0 00000000 00001000 00001004 0 0
1 0 0 00000000 00000000 0 0 00000000 00001004 00001008 0 0
1 0 0 00000000 00000000 0 0 00000000 00001008 0000100c 0 0
# Two taken resolutions for 0x1020 fill the BTB and saturate the counter
1 0 1 00001020 00023200 1 0 00000000 0000100c 00001010 0 0
1 0 1 00001020 00023200 1 0 00000000 00001010 00001014 0 0
1 0 0 00000000 00000000 0 0 00000000 00001014 00001018 0 0
1 0 0 00000000 00000000 0 0 00000000 00001018 0000101c 0 0
1 0 0 00000000 00000000 0 0 00000000 0000101c 00001020 0 0
# Hit at 0x1020, upper bits of the target come from the fetch PC
1 1 0 00000000 00000000 0 0 00000000 00001020 00003200 1 1
1 0 0 00000000 00000000 0 0 00000000 00003200 00003204 0 0
# Resolve and fetch 0x3204 in the same cycle
1 1 1 00003204 00001100 1 0 00000000 00003204 00001100 1 1
1 0 0 00000000 00000000 0 0 00000000 00001100 00001104 0 0
# Same index as 0x3204 but another tag
1 1 0 00000000 00000000 0 0 00000000 00001104 00001108 0 0
# Not taken resolutions pull 0x1020 back to weak not taken
1 0 1 00001020 00000000 0 0 00000000 00001108 0000110c 0 0
1 0 1 00001020 00000000 0 0 00000000 0000110c 00001110 0 0
1 0 0 00000000 00000000 0 1 00001020 00001110 00001114 0 0
# Valid hit but the counter says fall through
1 1 0 00000000 00000000 0 0 00000000 00001020 00001024 0 1
# Redirect wins over a predicted taken hit
1 0 0 00000000 00000000 0 1 00003204 00001024 00001028 0 0
1 1 0 00000000 00000000 0 1 00002000 00003204 00001100 1 1
1 0 0 00000000 00000000 0 1 00003204 00002000 00002004 0 0
# Stall with resolutions and a redirect, all ignored
0 1 1 00003204 00000000 0 0 00000000 00003204 00003208 0 0
0 1 1 00002008 00001500 1 1 00004000 00003204 00003208 0 0
# Counter for 0x3204 still predicts taken
1 1 0 00000000 00000000 0 0 00000000 00003204 00001100 1 1
1 0 0 00000000 00000000 0 1 00002008 00001100 00001104 0 0
# No row was written for 0x2008 during the stall
1 1 0 00000000 00000000 0 0 00000000 00002008 0000200c 0 0
1 0 0 00000000 00000000 0 0 00000000 0000200c 00002010 0 0
1 0 0 00000000 00000000 0 0 00000000 00002010 00002014 0 0
1 0 0 00000000 00000000 0 0 00000000 00002014 00002018 0 0
